/* rtl/armIsaPkg.sv */
// ARM instruction set encodings
package armIsaPkg;

   // Condition field, 4'b1111 is reserved
   typedef enum logic [3:0] {
      condEq = 4'b0000,
      condNe = 4'b0001,
      condCs = 4'b0010,
      condCc = 4'b0011,
      condMi = 4'b0100,
      condPl = 4'b0101,
      condVs = 4'b0110,
      condVc = 4'b0111,
      condHi = 4'b1000,
      condLs = 4'b1001,
      condGe = 4'b1010,
      condLt = 4'b1011,
      condGt = 4'b1100,
      condLe = 4'b1101,
      condAl = 4'b1110
   } cond_e;

   // Bits [27:26]
   typedef enum logic [1:0] {
      dataProc = 2'b00,
      memory   = 2'b01,
      branch   = 2'b10
   } opClass_e;

   // Data-processing funct field
   localparam logic [3:0] functAnd = 4'b0000;
   localparam logic [3:0] functSub = 4'b0010;
   localparam logic [3:0] functAdd = 4'b0100;
   localparam logic [3:0] functOrr = 4'b1100;

   typedef struct packed {
      cond_e       cond;
      opClass_e    op;
      logic        immBit;    // Imm8 when set, rm otherwise
      logic [3:0]  funct4;
      logic        sBit;      // Update flags
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] operand2;  // Imm8 or {0000, rm}
   } dpInstr_t;

   typedef struct packed {
      cond_e       cond;
      opClass_e    op;
      logic [4:0]  ctrlBits;  // I P U B W, fixed 01100
      logic        lBit;      // LDR when set
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] imm12;     // Zero-extended offset
   } memInstr_t;

   typedef struct packed {
      cond_e       cond;
      opClass_e    op;
      logic        brBit;     // Always one for B
      logic        link;
      logic [23:0] imm24;     // Signed word offset
   } brInstr_t;

   // One fetched word, three views
   typedef union packed {
      dpInstr_t  dp;
      memInstr_t mem;
      brInstr_t  br;
   } instrWord_u;

   localparam logic [3:0] pcReg = 4'd15;

endpackage

/* rtl/armCtrlPkg.sv */
// Core control and flag types
package armCtrlPkg;

   typedef enum logic [1:0] {
      aluAdd = 2'b00,
      aluSub = 2'b01,
      aluAnd = 2'b10,
      aluOrr = 2'b11
   } aluOp_e;

   // Immediate extension modes
   typedef enum logic [1:0] {
      imm8     = 2'b00,
      imm12    = 2'b01,
      branch24 = 2'b10
   } immSel_e;

   typedef struct packed {
      logic    regW;         // Ungated register write
      logic    memW;         // Ungated store
      logic    memStrobe;    // Any LDR or STR
      logic    memToReg;     // Result from readData
      logic    aluSrc;       // Second operand is the immediate
      immSel_e immSel;
      aluOp_e  aluOp;
      logic    flagWriteNz;
      logic    flagWriteCv;
      logic    pcs;          // Instruction may redirect the PC
      logic    regSrcA;      // Read R15 on port A
      logic    regSrcB;      // Read rd on port B for STR
   } ctrl_t;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

endpackage

/* rtl/regFile.sv */
// Register file
`timescale 1ns/1ps

module regFile (
   input  logic        clk,
   input  logic        writeEnable,
   input  logic [3:0]  readAddrA,
   input  logic [3:0]  readAddrB,
   input  logic [3:0]  writeAddr,
   input  logic [31:0] writeValue,
   input  logic [31:0] pcPlus8,
   output logic [31:0] readA,
   output logic [31:0] readB
);

   logic [31:0] regs [0:14];  // R0 to R14, R15 lives in the datapath

   // A write to R15 goes to the PC instead
   always_ff @(posedge clk) begin
      if (writeEnable && (writeAddr != armIsaPkg::pcReg)) begin
         regs[writeAddr] <= writeValue;
      end
   end

   // Combinational reads
   assign readA = (readAddrA == armIsaPkg::pcReg) ? pcPlus8 : regs[readAddrA];
   assign readB = (readAddrB == armIsaPkg::pcReg) ? pcPlus8 : regs[readAddrB];

endmodule

/* rtl/armAlu.sv */
// ALU with NZCV generation
`timescale 1ns/1ps

module armAlu (
   input  logic [31:0]        a,
   input  logic [31:0]        b,
   input  armCtrlPkg::aluOp_e aluOp,
   output logic [31:0]        result,
   output armCtrlPkg::flags_t aluFlags
);

   logic        isSub;
   logic        isArith;
   logic [31:0] bMux;  // b or its complement
   logic [32:0] sum;   // Carry out in bit 32

   assign isSub   = (aluOp == armCtrlPkg::aluSub);
   assign isArith = (aluOp == armCtrlPkg::aluAdd) || isSub;

   // One adder, SUB is a + ~b + 1
   assign bMux = isSub ? ~b : b;
   assign sum  = {1'b0, a} + {1'b0, bMux} + {32'b0, isSub};

   always_comb begin
      case (aluOp)
         armCtrlPkg::aluAdd: result = sum[31:0];
         armCtrlPkg::aluSub: result = sum[31:0];
         armCtrlPkg::aluAnd: result = a & b;
         armCtrlPkg::aluOrr: result = a | b;
         default:            result = sum[31:0];
      endcase
   end

   assign aluFlags.n = result[31];
   assign aluFlags.z = (result == 32'b0);
   assign aluFlags.c = isArith & sum[32];  // No borrow on SUB
   // Operands agree in sign and the sum does not
   assign aluFlags.v = isArith & ~(a[31] ^ bMux[31]) & (a[31] ^ sum[31]);

endmodule

/* rtl/armDecoder.sv */
// Instruction decoder
`timescale 1ns/1ps

module armDecoder (
   input  armIsaPkg::instrWord_u instr,
   output armCtrlPkg::ctrl_t     ctrl
);

   armCtrlPkg::aluOp_e dpOp;
   logic               isArith;

   // ALU decoder
   always_comb begin
      case (instr.dp.funct4)
         armIsaPkg::functAdd: dpOp = armCtrlPkg::aluAdd;
         armIsaPkg::functSub: dpOp = armCtrlPkg::aluSub;
         armIsaPkg::functAnd: dpOp = armCtrlPkg::aluAnd;
         armIsaPkg::functOrr: dpOp = armCtrlPkg::aluOrr;
         default:             dpOp = armCtrlPkg::aluAdd;  // Unsupported funct
      endcase
   end

   assign isArith = (dpOp == armCtrlPkg::aluAdd) || (dpOp == armCtrlPkg::aluSub);

   // Main decoder
   always_comb begin
      ctrl = '0;
      case (instr.dp.op)
         armIsaPkg::dataProc: begin
            ctrl.regW        = 1'b1;
            ctrl.aluSrc      = instr.dp.immBit;
            ctrl.immSel      = armCtrlPkg::imm8;
            ctrl.aluOp       = dpOp;
            ctrl.flagWriteNz = instr.dp.sBit;
            ctrl.flagWriteCv = instr.dp.sBit & isArith;  // Logic ops keep C and V
            ctrl.pcs         = (instr.dp.rd == armIsaPkg::pcReg);  // Write to R15
         end
         armIsaPkg::memory: begin
            ctrl.memStrobe = 1'b1;
            ctrl.aluSrc    = 1'b1;  // rn + imm12
            ctrl.immSel    = armCtrlPkg::imm12;
            ctrl.aluOp     = armCtrlPkg::aluAdd;
            if (instr.mem.lBit) begin
               ctrl.regW     = 1'b1;  // LDR
               ctrl.memToReg = 1'b1;
            end else begin
               ctrl.memW    = 1'b1;   // STR
               ctrl.regSrcB = 1'b1;   // Store data from rd
            end
         end
         armIsaPkg::branch: begin
            ctrl.pcs     = 1'b1;
            ctrl.regSrcA = 1'b1;  // Target is PC+8 plus offset
            ctrl.aluSrc  = 1'b1;
            ctrl.immSel  = armCtrlPkg::branch24;
            ctrl.aluOp   = armCtrlPkg::aluAdd;
         end
         default: ctrl = '0;  // Op 11 does nothing
      endcase
   end

endmodule

/* rtl/condUnit.sv */
// Condition check and flag registers
`timescale 1ns/1ps

module condUnit (
   input  logic               clk,
   input  logic               reset,
   input  armIsaPkg::cond_e   cond,
   input  armCtrlPkg::ctrl_t  ctrl,
   input  armCtrlPkg::flags_t aluFlags,
   output logic               regWrite,
   output logic               memWrite,
   output logic               memStrobe,
   output logic               pcSrc
);

   armCtrlPkg::flags_t flags;  // Stored NZCV
   logic               condEx;
   logic               ge;
   logic               flagWriteNz;
   logic               flagWriteCv;

   // NZ and CV load independently
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else begin
         if (flagWriteNz) begin
            flags.n <= aluFlags.n;
            flags.z <= aluFlags.z;
         end
         if (flagWriteCv) begin
            flags.c <= aluFlags.c;
            flags.v <= aluFlags.v;
         end
      end
   end

   assign ge = (flags.n == flags.v);  // Signed greater or equal

   always_comb begin
      case (cond)
         armIsaPkg::condEq: condEx = flags.z;
         armIsaPkg::condNe: condEx = ~flags.z;
         armIsaPkg::condCs: condEx = flags.c;
         armIsaPkg::condCc: condEx = ~flags.c;
         armIsaPkg::condMi: condEx = flags.n;
         armIsaPkg::condPl: condEx = ~flags.n;
         armIsaPkg::condVs: condEx = flags.v;
         armIsaPkg::condVc: condEx = ~flags.v;
         armIsaPkg::condHi: condEx = flags.c & ~flags.z;
         armIsaPkg::condLs: condEx = ~flags.c | flags.z;
         armIsaPkg::condGe: condEx = ge;
         armIsaPkg::condLt: condEx = ~ge;
         armIsaPkg::condGt: condEx = ~flags.z & ge;
         armIsaPkg::condLe: condEx = flags.z | ~ge;
         armIsaPkg::condAl: condEx = 1'b1;
         default:           condEx = 1'b0;  // Reserved code never executes
      endcase
   end

   // Every state change waits on the condition
   assign flagWriteNz = ctrl.flagWriteNz & condEx;
   assign flagWriteCv = ctrl.flagWriteCv & condEx;
   assign regWrite    = ctrl.regW & condEx;
   assign memWrite    = ctrl.memW & condEx;
   assign memStrobe   = ctrl.memStrobe & condEx;
   assign pcSrc       = ctrl.pcs & condEx;

endmodule

/* rtl/armDatapath.sv */
// Core datapath
`timescale 1ns/1ps

module armDatapath #(
   parameter logic [31:0] resetPc = 32'h0
) (
   input  logic                  clk,
   input  logic                  reset,
   input  armIsaPkg::instrWord_u instr,
   input  armCtrlPkg::ctrl_t     ctrl,
   input  logic                  regWrite,
   input  logic                  pcSrc,
   input  logic [31:0]           readData,
   output logic [31:0]           pc,
   output logic [31:0]           dataAddr,
   output logic [31:0]           writeData,
   output armCtrlPkg::flags_t    aluFlags
);

   logic [31:0] pcPlus4;
   logic [31:0] pcPlus8;
   logic [31:0] pcNext;
   logic [31:0] extImm;
   logic [31:0] srcA;
   logic [31:0] srcB;
   logic [31:0] aluResult;
   logic [31:0] result;
   logic [3:0]  readAddrA;
   logic [3:0]  readAddrB;

   assign pcPlus4 = pc + 32'd4;
   assign pcPlus8 = pc + 32'd8;   // R15 value seen by instructions
   assign pcNext  = pcSrc ? result : pcPlus4;  // Branch or write to R15

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pc <= resetPc;
      end else begin
         pc <= pcNext;
      end
   end

   assign readAddrA = ctrl.regSrcA ? armIsaPkg::pcReg : instr.dp.rn;
   assign readAddrB = ctrl.regSrcB ? instr.mem.rd : instr.dp.operand2[3:0];  // rd or rm

   // Immediate extension
   always_comb begin
      case (ctrl.immSel)
         armCtrlPkg::imm8:     extImm = {24'b0, instr.dp.operand2[7:0]};
         armCtrlPkg::imm12:    extImm = {20'b0, instr.mem.imm12};
         armCtrlPkg::branch24: extImm = {{6{instr.br.imm24[23]}}, instr.br.imm24, 2'b00};
         default:              extImm = 32'b0;
      endcase
   end

   regFile regFile_inst (
      .clk(clk), .writeEnable(regWrite),
      .readAddrA(readAddrA), .readAddrB(readAddrB), .writeAddr(instr.dp.rd),
      .writeValue(result), .pcPlus8(pcPlus8),
      .readA(srcA), .readB(writeData)
   );

   assign srcB = ctrl.aluSrc ? extImm : writeData;

   armAlu armAlu_inst (
      .a(srcA), .b(srcB), .aluOp(ctrl.aluOp),
      .result(aluResult), .aluFlags(aluFlags)
   );

   assign result   = ctrl.memToReg ? readData : aluResult;  // LDR takes memory data
   assign dataAddr = aluResult;

endmodule

/* rtl/armCore.sv */
// Single-cycle ARM core
`timescale 1ns/1ps

module armCore #(
   parameter logic [31:0] resetPc = 32'h0
) (
   input  logic                  clk,
   input  logic                  reset,
   input  armIsaPkg::instrWord_u instr,
   input  logic [31:0]           readData,
   output logic [31:0]           pc,
   output logic [31:0]           dataAddr,
   output logic [31:0]           writeData,
   output logic                  memWrite,
   output logic                  memStrobe
);

   armCtrlPkg::ctrl_t  ctrl;      // Ungated controls
   armCtrlPkg::flags_t aluFlags;  // Flags of the current result
   logic               regWrite;
   logic               pcSrc;

   armDecoder armDecoder_inst (
      .instr(instr), .ctrl(ctrl)
   );

   condUnit condUnit_inst (
      .clk(clk), .reset(reset), .cond(instr.dp.cond), .ctrl(ctrl), .aluFlags(aluFlags),
      .regWrite(regWrite), .memWrite(memWrite), .memStrobe(memStrobe), .pcSrc(pcSrc)
   );

   armDatapath #(
      .resetPc(resetPc)
   ) armDatapath_inst (
      .clk(clk), .reset(reset), .instr(instr), .ctrl(ctrl),
      .regWrite(regWrite), .pcSrc(pcSrc), .readData(readData),
      .pc(pc), .dataAddr(dataAddr), .writeData(writeData), .aluFlags(aluFlags)
   );

endmodule

/* testbench/armCore_sva.sv */
// Core port assertions
`timescale 1ns/1ps

module armCoreSva (
   input logic        clk,
   input logic        reset,
   input logic [31:0] pc,
   input logic        pcSrc,     // Taken branch or write to R15
   input logic        memWrite,
   input logic        memStrobe
);

   // A store is always a memory access
   property storeHasStrobe;
      @(posedge clk) disable iff (reset) memWrite |-> memStrobe;
   endproperty

   property pcWordAligned;
      @(posedge clk) disable iff (reset) pc[1:0] == 2'b00;
   endproperty

   // Sequential fetch when nothing redirects
   property pcStepsByFour;
      @(posedge clk) disable iff (reset) !pcSrc |=> pc == $past(pc) + 32'd4;
   endproperty

   strobeCheck: assert property (storeHasStrobe) else $error("memWrite without memStrobe");
   alignCheck:  assert property (pcWordAligned) else $error("pc is not word aligned");
   stepCheck:   assert property (pcStepsByFour) else $error("pc did not advance by 4");

endmodule

bind armCore armCoreSva armCoreSva_inst (
   .clk(clk), .reset(reset), .pc(pc), .pcSrc(pcSrc),
   .memWrite(memWrite), .memStrobe(memStrobe)
);

/* testbench/armCoreChecker.sv */
// Data port store checker
`timescale 1ns/1ps

module armCoreChecker (
   input  logic        clk,
   input  logic        reset,
   input  logic        checkEnable,  // High while the program runs
   input  logic        memWrite,
   input  logic        memStrobe,
   input  logic [31:0] dataAddr,
   input  logic [31:0] writeData,
   input  logic        expStore,     // Current row expectations
   input  logic        expLoad,
   input  logic [31:0] expAddr,
   input  logic [31:0] expData,
   output int          addrErrors,
   output int          dataErrors,
   output int          storeErrors,  // Missing or unexpected stores
   output int          strobeErrors
);

   always @(posedge clk or posedge reset) begin
      if (reset) begin
         addrErrors   <= 0;
         dataErrors   <= 0;
         storeErrors  <= 0;
         strobeErrors <= 0;
      end else if (checkEnable) begin
         // Any executed LDR or STR
         if (memStrobe !== (expStore | expLoad)) begin
            $display("Mismatch at %0t ns: memStrobe is %b, expected %b",
                     $time, memStrobe, expStore | expLoad);
            strobeErrors <= strobeErrors + 1;
         end
         if (expStore && memWrite !== 1'b1) begin
            $display("At %0t ns a store of %h to address %h was expected but did not happen",
                     $time, expData, expAddr);
            storeErrors <= storeErrors + 1;
         end else if (!expStore && memWrite !== 1'b0) begin
            $display("At %0t ns an unexpected store of %h to address %h happened",
                     $time, writeData, dataAddr);
            storeErrors <= storeErrors + 1;
         end else if (expStore || expLoad) begin
            if (dataAddr !== expAddr) begin  // rn plus offset
               $display("Mismatch at %0t ns: dataAddr is %h, expected %h",
                        $time, dataAddr, expAddr);
               addrErrors <= addrErrors + 1;
            end
            if (expStore && writeData !== expData) begin
               $display("Mismatch at %0t ns: writeData is %h, expected %h",
                        $time, writeData, expData);
               dataErrors <= dataErrors + 1;
            end
         end
      end
   end

endmodule

/* testbench/armCoreTb.sv */
// ARM core testbench
`timescale 1ns/1ps

module armCoreTb;

   localparam int          numRows   = 64;
   localparam int          maxCycles = 100;
   localparam logic [31:0] endAddr   = 32'h8C;  // First address past the program

   // ARM condition and funct values
   localparam logic [3:0] ccEq  = 4'h0;
   localparam logic [3:0] ccNe  = 4'h1;
   localparam logic [3:0] ccMi  = 4'h4;
   localparam logic [3:0] ccVs  = 4'h6;
   localparam logic [3:0] ccAl  = 4'hE;
   localparam logic [3:0] opAnd = 4'h0;
   localparam logic [3:0] opSub = 4'h2;
   localparam logic [3:0] opAdd = 4'h4;
   localparam logic [3:0] opOrr = 4'hC;

   typedef struct packed {
      logic [31:0] instr;
      logic        store;  // A store is expected this cycle
      logic        load;   // A load is expected this cycle
      logic [31:0] addr;
      logic [31:0] data;
   } progRow_t;

   logic                  clk;
   logic                  reset;
   armIsaPkg::instrWord_u instrBus;
   logic [31:0]           readData;
   logic [31:0]           pc;
   logic [31:0]           dataAddr;
   logic [31:0]           writeData;
   logic                  memWrite;
   logic                  memStrobe;
   logic                  checkOn;
   progRow_t              curRow;
   progRow_t              progTable [0:numRows-1];
   logic [31:0]           dataMem [0:255];
   int                    rowCount;
   int                    cycles;
   int                    addrErrors;
   int                    dataErrors;
   int                    storeErrors;
   int                    strobeErrors;
   logic                  timedOut;

   always #2 clk = ~clk;  // 4 ns period

   armCore armCore_inst (
      .clk(clk), .reset(reset), .instr(instrBus), .readData(readData),
      .pc(pc), .dataAddr(dataAddr), .writeData(writeData),
      .memWrite(memWrite), .memStrobe(memStrobe)
   );

   armCoreChecker armCoreChecker_inst (
      .clk(clk), .reset(reset), .checkEnable(checkOn),
      .memWrite(memWrite), .memStrobe(memStrobe),
      .dataAddr(dataAddr), .writeData(writeData),
      .expStore(curRow.store), .expLoad(curRow.load),
      .expAddr(curRow.addr), .expData(curRow.data),
      .addrErrors(addrErrors), .dataErrors(dataErrors), .storeErrors(storeErrors),
      .strobeErrors(strobeErrors)
   );

   function automatic logic [31:0] fillWord(input logic [31:0] addr);
      return {~addr[15:0], addr[15:0]};  // Distinct word per address
   endfunction

   // Data memory model
   assign readData = dataMem[dataAddr[9:2]];

   always @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 256; i++) begin
            dataMem[i[7:0]] <= fillWord({i[29:0], 2'b00});
         end
         dataMem[8'h21] <= 32'h7FFF_FFF0;  // Word 0x84, near the signed limit
      end else if (memWrite) begin
         dataMem[dataAddr[9:2]] <= writeData;
      end
   end

   function automatic logic [31:0] encodeDpImm(input logic [3:0] cond, input logic [3:0] funct,
      input logic sBit, input logic [3:0] rn, input logic [3:0] rd, input logic [7:0] imm8);
      return {cond, 2'b00, 1'b1, funct, sBit, rn, rd, 4'h0, imm8};
   endfunction

   function automatic logic [31:0] encodeDpReg(input logic [3:0] cond, input logic [3:0] funct,
      input logic sBit, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rm);
      return {cond, 2'b00, 1'b0, funct, sBit, rn, rd, 8'h00, rm};
   endfunction

   function automatic logic [31:0] encodeMem(input logic [3:0] cond, input logic load,
      input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] imm12);
      return {cond, 2'b01, 5'b01100, load, rn, rd, imm12};  // Pre-index, add offset
   endfunction

   function automatic logic [31:0] encodeBranch(input logic [3:0] cond, input logic [23:0] imm24);
      return {cond, 3'b101, 1'b0, imm24};
   endfunction

   task automatic addRow(input logic [31:0] instr, input logic store,
      input logic [31:0] addr, input logic [31:0] data);
      progTable[rowCount[5:0]] = {instr, store, 1'b0, addr, data};
      rowCount = rowCount + 1;
   endtask

   // LDR row with its expected address
   task automatic addLoadRow(input logic [31:0] instr, input logic [31:0] addr);
      progTable[rowCount[5:0]] = {instr, 1'b0, 1'b1, addr, 32'h0};
      rowCount = rowCount + 1;
   endtask

   task automatic loadProgram();
      for (int i = 0; i < numRows; i++) begin
         progTable[i[5:0]] = '0;  // Empty rows fetch as a failing EQ
      end
      rowCount = 0;
      addRow(encodeDpImm(ccAl, opAnd, 1'b0, 4'd0, 4'd0, 8'h00), 1'b0, 32'h0, 32'h0);
      addRow(encodeDpImm(ccAl, opAdd, 1'b0, 4'd0, 4'd1, 8'd200), 1'b0, 32'h0, 32'h0);
      addRow(encodeDpImm(ccAl, opAdd, 1'b0, 4'd0, 4'd2, 8'd75), 1'b0, 32'h0, 32'h0);
      addRow(encodeDpReg(ccAl, opAdd, 1'b0, 4'd1, 4'd3, 4'd2), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd3, 12'h040), 1'b1, 32'h40, 32'd200 + 32'd75);
      addRow(encodeDpImm(ccAl, opSub, 1'b0, 4'd1, 4'd4, 8'd13), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd4, 12'h044), 1'b1, 32'h44, 32'd200 - 32'd13);
      addRow(encodeDpReg(ccAl, opSub, 1'b0, 4'd2, 4'd5, 4'd1), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd5, 12'h048), 1'b1, 32'h48, 32'd75 - 32'd200);
      addRow(encodeDpImm(ccAl, opAnd, 1'b0, 4'd1, 4'd6, 8'h0F), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd6, 12'h04C), 1'b1, 32'h4C, 32'd200 & 32'h0F);
      addRow(encodeDpReg(ccAl, opAnd, 1'b0, 4'd1, 4'd7, 4'd2), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd7, 12'h050), 1'b1, 32'h50, 32'd200 & 32'd75);
      addRow(encodeDpImm(ccAl, opOrr, 1'b0, 4'd2, 4'd8, 8'h30), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd8, 12'h054), 1'b1, 32'h54, 32'd75 | 32'h30);
      addRow(encodeDpReg(ccAl, opOrr, 1'b0, 4'd1, 4'd9, 4'd2), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccAl, 1'b0, 4'd1, 4'd9, 12'h004), 1'b1, 32'd204, 32'd200 | 32'd75);
      // Load, add, store back
      addLoadRow(encodeMem(ccAl, 1'b1, 4'd0, 4'd10, 12'h080), 32'h80);
      addRow(encodeDpImm(ccAl, opAdd, 1'b0, 4'd10, 4'd11, 8'h21), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd11, 12'h058), 1'b1, 32'h58,
             fillWord(32'h80) + 32'h21);
      // SUBS to zero sets Z
      addRow(encodeDpReg(ccAl, opSub, 1'b1, 4'd1, 4'd12, 4'd1), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccEq, 1'b0, 4'd0, 4'd1, 12'h05C), 1'b1, 32'h5C, 32'd200);
      addRow(encodeMem(ccNe, 1'b0, 4'd0, 4'd2, 12'h060), 1'b0, 32'h0, 32'h0);
      // Signed overflow sets V and N
      addLoadRow(encodeMem(ccAl, 1'b1, 4'd0, 4'd13, 12'h084), 32'h84);
      addRow(encodeDpImm(ccAl, opAdd, 1'b1, 4'd13, 4'd13, 8'h20), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccVs, 1'b0, 4'd0, 4'd13, 12'h064), 1'b1, 32'h64,
             32'h7FFF_FFF0 + 32'h20);
      addRow(encodeDpImm(ccAl, opAdd, 1'b0, 4'd0, 4'd14, 8'h00), 1'b0, 32'h0, 32'h0);  // No S
      addRow(encodeMem(ccMi, 1'b0, 4'd0, 4'd2, 12'h068), 1'b1, 32'h68, 32'd75);
      addRow(encodeMem(ccEq, 1'b0, 4'd0, 4'd2, 12'h06C), 1'b0, 32'h0, 32'h0);
      // Branch at 0x74 to 0x74 + 8 + 4
      addRow(encodeBranch(ccAl, 24'd1), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd1, 12'h070), 1'b0, 32'h0, 32'h0);  // Skipped
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd1, 12'h074), 1'b0, 32'h0, 32'h0);  // Skipped
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd3, 12'h078), 1'b1, 32'h78, 32'd200 + 32'd75);
      // R15 reads as its own address plus 8
      addRow(encodeDpImm(ccAl, opAdd, 1'b0, 4'd15, 4'd5, 8'h00), 1'b0, 32'h0, 32'h0);
      addRow(encodeMem(ccAl, 1'b0, 4'd0, 4'd5, 12'h07C), 1'b1, 32'h7C, 32'h84 + 32'd8);
   endtask

   initial begin
      clk      = 1'b0;
      reset    = 1'b1;
      instrBus = '0;
      checkOn  = 1'b0;
      curRow   = '0;
      cycles   = 0;
      timedOut = 1'b0;
      loadProgram();
      repeat (2) @(posedge clk);  // Two reset cycles
      #1;
      reset   = 1'b0;
      checkOn = 1'b1;
      while (pc !== endAddr && cycles < maxCycles) begin
         curRow   = progTable[pc[7:2]];  // Fetch plus expectations
         instrBus = curRow.instr;
         @(posedge clk);
         #1;
         cycles = cycles + 1;
      end
      checkOn = 1'b0;
      if (pc !== endAddr) begin
         timedOut = 1'b1;
         $display("Timeout: pc is %h after %0d cycles and never reached %h",
                  pc, cycles, endAddr);
      end
      $display("Errors: %0d address, %0d data, %0d store, %0d strobe, %0d timeout",
               addrErrors, dataErrors, storeErrors, strobeErrors, timedOut);
      if (addrErrors + dataErrors + storeErrors + strobeErrors == 0 && !timedOut) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* armCore.f */
rtl/armIsaPkg.sv
rtl/armCtrlPkg.sv
rtl/regFile.sv
rtl/armAlu.sv
rtl/armDecoder.sv
rtl/condUnit.sv
rtl/armDatapath.sv
rtl/armCore.sv
testbench/armCore_sva.sv
testbench/armCoreChecker.sv
testbench/armCoreTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the armCore testbench with Verilator
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert --top-module armCoreTb -f armCore.f \
   -o armCoreSim > "$LOG" 2>&1 &&
   ./obj_dir/armCoreSim >> "$LOG" 2>&1 ||
   echo "tests failed" >> "$LOG"
cat "$LOG"
if grep -q "tests failed" "$LOG"; then
   exit 1
fi
exit 0
